// File: flash_pkg.sv
package flash_pkg;

  // ================================================
  // Command opcodes
  // ================================================

  localparam logic [7:0] op_read    = 8'h03; // Continuous read.
  localparam logic [7:0] op_program = 8'h02; // Page program.
  localparam logic [7:0] op_wren    = 8'h06; // Write enable.
  localparam logic [7:0] op_wrdi    = 8'h04; // Write disable.
  localparam logic [7:0] op_rdsr    = 8'h05; // Read status.
  localparam logic [7:0] op_wrsr    = 8'h01; // Write status.

  // ================================================
  // Status register layout
  // ================================================

  // Bit 0 would be the busy flag on a real part. Writes complete at once here,
  // so it always reads as zero.
  localparam int st_wel_bit = 1; // Write-enable latch.
  localparam int st_bp_bit  = 2; // Block protect.

  // ================================================
  // Frame phases
  // ================================================

  // A frame starts in op. Read and program pass through addr before data.
  // Opcodes that are not recognised park in ignore until ss_n rises.
  typedef enum logic [1:0] {
    op     = 2'd0,
    addr   = 2'd1,
    data   = 2'd2,
    ignore = 2'd3
  } frame_state_t;

  // Program runs wrap inside a window of this many bytes.
  localparam int page_bytes = 256;

endpackage

// File: wb_if.sv
`timescale 1ns/100ps

interface wb_if #(
  parameter int addr_bits = 12
) ();

  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [addr_bits-1:0] adr;
  logic [7:0]           dat_w;
  logic [7:0]           dat_r;
  logic                 ack; // Zero-wait, so it follows stb in the same cycle.

  // The command engine starts every cycle.
  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  // The storage array answers.
  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

// File: spi_shift_io.sv
`timescale 1ns/100ps

module spi_shift_io (
  input  logic       sck,
  input  logic       reset,
  input  logic       ss_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_next,
  output logic       byte_done,
  input  logic [7:0] tx_byte,
  input  logic       tx_load
);

  logic       frame_rst;
  logic [2:0] bit_cnt;
  logic [7:0] rx_sr;
  logic [7:0] tx_sr;

  // A deselected device forgets the frame it was in.
  assign frame_rst = reset | ss_n;

  // ================================================
  // Receive side
  // ================================================

  always_ff @(posedge sck or posedge frame_rst) begin
    if (frame_rst) begin
      bit_cnt <= 3'd0;
    end else begin
      bit_cnt <= bit_cnt + 3'd1; // Wraps every eight bits.
    end
  end

  always_ff @(posedge sck or posedge frame_rst) begin
    if (frame_rst) begin
      rx_sr <= 8'h00;
    end else begin
      rx_sr <= {rx_sr[6:0], mosi};
    end
  end

  // The edge that samples the eighth bit of a byte closes it.
  assign byte_done = (bit_cnt == 3'd7);

  // Before that edge the register holds the first seven bits in rx_byte[6:0].
  // After it, rx_byte is the complete byte for one whole cycle.
  assign rx_byte = rx_sr;
  assign rx_next = mosi; // Bit being sampled on the coming edge.

  // ================================================
  // Transmit side
  // ================================================

  // Ones are shifted in behind the data. A frame that never loads a byte
  // therefore reads back as all ones.
  always_ff @(posedge sck or posedge frame_rst) begin
    if (frame_rst) begin
      tx_sr <= 8'hff;
    end else if (tx_load) begin
      tx_sr <= tx_byte; // MSB appears on miso right after this edge.
    end else begin
      tx_sr <= {tx_sr[6:0], 1'b1};
    end
  end

  // The reset value of tx_sr already keeps the pin high when deselected.
  assign miso = tx_sr[7];

endmodule

// File: flash_cmd_engine.sv
`timescale 1ns/100ps

module flash_cmd_engine #(
  parameter int addr_bits = 12
) (
  input  logic       sck,
  input  logic       reset,
  input  logic       ss_n,
  input  logic [7:0] rx_byte,
  input  logic       rx_next,
  input  logic       byte_done,
  output logic [7:0] tx_byte,
  output logic       tx_load,
  input  logic       wel,
  input  logic       bp,
  input  logic [7:0] status,
  output logic       set_wel,
  output logic       clr_wel,
  output logic       wr_status,
  output logic [7:0] wr_data,
  wb_if.master       bus
);

  localparam int pg_bits = $clog2(flash_pkg::page_bytes);

  flash_pkg::frame_state_t state;

  logic                 frame_rst;
  logic [7:0]           opcode;
  logic [1:0]           addr_cnt;
  logic [addr_bits-1:0] addr_q;
  logic [addr_bits-1:0] addr_full;
  logic [addr_bits-1:0] rd_addr;
  logic [addr_bits-1:0] pg_addr;
  logic [7:0]           cur_byte;
  logic                 wr_pend;
  logic                 wel_drop;
  logic                 is_read, is_prog, is_rdsr, is_wrsr;
  logic                 in_op, in_data;
  logic                 addr_last, prog_byte, rd_now, st_load;

  assign frame_rst = reset | ss_n;

  // ================================================
  // Decode
  // ================================================

  // The byte that completes on this edge, including the bit now on mosi.
  assign cur_byte  = {rx_byte[6:0], rx_next};
  assign addr_full = addr_bits'({addr_q, cur_byte}); // Upper address bits drop off.

  assign is_read = (opcode == flash_pkg::op_read);
  assign is_prog = (opcode == flash_pkg::op_program);
  assign is_rdsr = (opcode == flash_pkg::op_rdsr);
  assign is_wrsr = (opcode == flash_pkg::op_wrsr);

  assign in_op   = byte_done && (state == flash_pkg::op);
  assign in_data = byte_done && (state == flash_pkg::data);

  assign addr_last = byte_done && (state == flash_pkg::addr) && (addr_cnt == 2'd2);
  assign prog_byte = in_data && is_prog && wel && !bp; // Protected or locked runs are dropped.

  // Reads go out on the last address bit and then on every byte boundary.
  assign rd_now  = is_read && (addr_last || in_data);
  assign st_load = (in_op && cur_byte == flash_pkg::op_rdsr) || (in_data && is_rdsr);

  // ================================================
  // Frame sequencing
  // ================================================

  always_ff @(posedge sck or posedge frame_rst) begin
    if (frame_rst) begin
      state    <= flash_pkg::op;
      opcode   <= 8'h00;
      addr_cnt <= 2'd0;
      wr_pend  <= 1'b0;
    end else begin
      wr_pend <= prog_byte; // The write itself goes out one cycle later.
      if (byte_done) begin
        case (state)
          flash_pkg::op: begin
            opcode <= cur_byte;
            case (cur_byte)
              flash_pkg::op_read, flash_pkg::op_program: state <= flash_pkg::addr;
              flash_pkg::op_rdsr, flash_pkg::op_wrsr,
              flash_pkg::op_wren, flash_pkg::op_wrdi: state <= flash_pkg::data;
              default: state <= flash_pkg::ignore;
            endcase
          end
          flash_pkg::addr: begin
            addr_cnt <= addr_cnt + 2'd1;
            if (addr_cnt == 2'd2) begin
              state <= flash_pkg::data;
            end
          end
          default: state <= state; // Data and ignore last until ss_n rises.
        endcase
      end
    end
  end

  // Address capture and the running read and program addresses.
  always_ff @(posedge sck) begin
    if (byte_done && state == flash_pkg::addr) begin
      addr_q <= addr_full;
    end
    if (addr_last) begin
      rd_addr <= addr_full + 1'b1;
      pg_addr <= addr_full;
    end else begin
      if (rd_now) begin
        rd_addr <= rd_addr + 1'b1; // Wraps at the top of the array.
      end
      if (wr_pend) begin
        pg_addr <= {pg_addr[addr_bits-1:pg_bits], pg_addr[pg_bits-1:0] + 1'b1};
      end
    end
  end

  // Remembers that a frame changed the array or the status register.
  // The first edge after ss_n rises uses it to clear WEL.
  always_ff @(posedge sck or posedge reset) begin
    if (reset) begin
      wel_drop <= 1'b0;
    end else if (ss_n) begin
      wel_drop <= 1'b0;
    end else if (prog_byte || wr_status) begin
      wel_drop <= 1'b1;
    end
  end

  // ================================================
  // Status control
  // ================================================

  assign set_wel   = in_op && (cur_byte == flash_pkg::op_wren);
  assign clr_wel   = (in_op && cur_byte == flash_pkg::op_wrdi) || (ss_n && wel_drop);
  assign wr_status = in_data && is_wrsr && wel;
  assign wr_data   = cur_byte;

  // ================================================
  // Bus master and serializer feed
  // ================================================

  assign bus.cyc   = rd_now || wr_pend;
  assign bus.stb   = rd_now || wr_pend;
  assign bus.we    = wr_pend;
  assign bus.adr   = wr_pend ? pg_addr : (state == flash_pkg::data ? rd_addr : addr_full);
  assign bus.dat_w = rx_byte; // Holds the finished byte during the write cycle.

  assign tx_byte = st_load ? status : bus.dat_r;
  assign tx_load = st_load || (rd_now && bus.ack);

endmodule

// File: flash_status_regs.sv
`timescale 1ns/100ps

module flash_status_regs (
  input  logic       sck,
  input  logic       reset,
  input  logic       set_wel,
  input  logic       clr_wel,
  input  logic       wr_status,
  input  logic [7:0] wdata,
  output logic       wel,
  output logic       bp,
  output logic [7:0] status
);

  // ================================================
  // Write-enable latch
  // ================================================

  // Deselecting the device does not touch this register; only reset does.
  always_ff @(posedge sck or posedge reset) begin
    if (reset) begin
      wel <= 1'b0;
    end else if (set_wel) begin
      wel <= 1'b1;
    end else if (clr_wel) begin
      wel <= 1'b0;
    end
  end

  // ================================================
  // Block protect
  // ================================================

  always_ff @(posedge sck or posedge reset) begin
    if (reset) begin
      bp <= 1'b0;
    end else if (wr_status) begin
      bp <= wdata[flash_pkg::st_bp_bit]; // The other written bits are not kept.
    end
  end

  // Unused positions, including the busy bit, read as zero.
  always_comb begin
    status = 8'h00;
    status[flash_pkg::st_wel_bit] = wel;
    status[flash_pkg::st_bp_bit]  = bp;
  end

endmodule

// File: flash_mem_array.sv
`timescale 1ns/100ps

module flash_mem_array #(
  parameter int addr_bits = 12
) (
  input logic  sck,
  wb_if.slave  bus
);

  localparam int depth = 2 ** addr_bits;

  // ================================================
  // Storage
  // ================================================

  // Contents power up undefined.
  logic [7:0] mem [depth];

  logic access;

  assign access = bus.cyc && bus.stb;

  // No wait states.
  assign bus.ack = access;

  // Asynchronous read, so data is ready in the same cycle as ack.
  assign bus.dat_r = mem[bus.adr];

  always_ff @(posedge sck) begin
    if (access && bus.ack && bus.we) begin
      mem[bus.adr] <= bus.dat_w; // Commits on the acknowledged edge.
    end
  end

endmodule

// File: spi_flash.sv
`timescale 1ns/100ps

module spi_flash #(
  parameter int addr_bits = 12
) (
  input  logic sck,
  input  logic reset,
  input  logic ss_n,
  input  logic mosi,
  output logic miso
);

  logic [7:0] rx_byte;
  logic       rx_next;
  logic       byte_done;
  logic [7:0] tx_byte;
  logic       tx_load;
  logic       wel;
  logic       bp;
  logic [7:0] status;
  logic       set_wel;
  logic       clr_wel;
  logic       wr_status;
  logic [7:0] wr_data;

  // ================================================
  // Internal bus and blocks
  // ================================================

  wb_if #(.addr_bits(addr_bits)) bus_if ();

  // Serial pins in and out.
  spi_shift_io shift_io_i (
    .sck       (sck),
    .reset     (reset),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .miso      (miso),
    .rx_byte   (rx_byte),
    .rx_next   (rx_next),
    .byte_done (byte_done),
    .tx_byte   (tx_byte),
    .tx_load   (tx_load)
  );

  flash_cmd_engine #(.addr_bits(addr_bits)) cmd_engine_i (
    .sck       (sck),
    .reset     (reset),
    .ss_n      (ss_n),
    .rx_byte   (rx_byte),
    .rx_next   (rx_next),
    .byte_done (byte_done),
    .tx_byte   (tx_byte),
    .tx_load   (tx_load),
    .wel       (wel),
    .bp        (bp),
    .status    (status),
    .set_wel   (set_wel),
    .clr_wel   (clr_wel),
    .wr_status (wr_status),
    .wr_data   (wr_data),
    .bus       (bus_if.master)
  );

  flash_status_regs status_regs_i (
    .sck       (sck),
    .reset     (reset),
    .set_wel   (set_wel),
    .clr_wel   (clr_wel),
    .wr_status (wr_status),
    .wdata     (wr_data),
    .wel       (wel),
    .bp        (bp),
    .status    (status)
  );

  flash_mem_array #(.addr_bits(addr_bits)) mem_array_i (
    .sck (sck),
    .bus (bus_if.slave)
  );

endmodule

// File: spi_flash_sva.sv
`timescale 1ns/100ps

module spi_flash_sva (
  input logic sck,
  input logic reset,
  input logic ss_n,
  input logic miso,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic tx_load
);

  int fail_cnt = 0; // Failed assertions so far.

  // ================================================
  // Wishbone rules
  // ================================================

  // Bus cycles only run inside a selected frame.
  stb_needs_cyc: assert property (@(posedge sck) disable iff (reset) stb |-> cyc && !ss_n)
    else begin
      $error("Wishbone stb high without cyc or outside a frame");
      fail_cnt++;
    end

  // The array has no wait states, so every strobe is answered at once.
  stb_gets_ack: assert property (@(posedge sck) disable iff (reset) stb |-> ack)
    else begin
      $error("Wishbone stb held without ack");
      fail_cnt++;
    end

  // ================================================
  // Pins and serializer
  // ================================================

  idle_miso_high: assert property (@(posedge sck) ss_n |-> miso)
    else begin
      $error("miso low while the device is deselected");
      fail_cnt++;
    end

  no_load_in_reset: assert property (@(posedge sck) reset |-> !tx_load)
    else begin
      $error("tx_load asserted during reset");
      fail_cnt++;
    end

endmodule

// The top level sees the pins, the internal bus and the serializer load.
bind spi_flash spi_flash_sva flash_sva_i (
  .sck     (sck),
  .reset   (reset),
  .ss_n    (ss_n),
  .miso    (miso),
  .cyc     (bus_if.cyc),
  .stb     (bus_if.stb),
  .ack     (bus_if.ack),
  .tx_load (tx_load)
);

// File: tb_spi_flash.sv
`timescale 1ns/100ps

module tb_spi_flash;

  localparam int addr_bits = 12;
  localparam int depth     = 2 ** addr_bits;

  logic        sck;
  logic        reset;
  logic        ss_n;
  logic        mosi;
  logic        miso;
  logic [7:0]  model_mem [depth];
  bit          model_ok [depth]; // Set once a byte has been programmed.
  logic        model_wel;
  logic        model_bp;
  logic [15:0] lfsr;
  logic [7:0]  tx_buf [64];
  logic [7:0]  rx_buf [64];
  int          check_cnt;
  int          err_cnt;
  int          tmo_cnt;
  int          sva_cnt;

  spi_flash #(.addr_bits(addr_bits)) spi_flash_i (
    .sck   (sck),
    .reset (reset),
    .ss_n  (ss_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  initial begin
    sck = 1'b0;
    forever #10 sck = ~sck;
  end

  // ================================================
  // Random source and checks
  // ================================================

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]}; // One LFSR step per bit.
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Fail %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // ================================================
  // SPI master
  // ================================================

  // miso moves just after a rising edge, so the falling edge sees a settled bit.
  task automatic shift_byte(input logic [7:0] tx, input bit first, output logic [7:0] rx);
    for (int k = 7; k >= 0; k--) begin
      @(posedge sck);
      if (first && k == 7) begin
        ss_n <= 1'b0; // Select together with the first bit.
      end
      mosi <= tx[k];
      @(negedge sck);
      rx[k] = miso;
    end
  endtask

  task automatic wait_idle();
    int n = 0;
    @(negedge sck);
    while (miso !== 1'b1 && n < 16) begin
      @(negedge sck);
      n++;
    end
    if (miso !== 1'b1) begin
      tmo_cnt++;
      $display("Timeout: miso did not return high after deselect");
    end
    repeat (2) @(posedge sck);
  endtask

  // The spare bit gives a final program byte its write cycle before ss_n rises.
  task automatic run_frame(input int n);
    logic [7:0] rx;
    for (int i = 0; i < n; i++) begin
      shift_byte(tx_buf[i], i == 0, rx);
      rx_buf[i] = rx;
    end
    @(posedge sck);
    mosi <= 1'b0;
    @(posedge sck);
    ss_n <= 1'b1;
    wait_idle();
  endtask

  task automatic load_header(input logic [7:0] op, input logic [23:0] a);
    tx_buf[0] = op;
    tx_buf[1] = a[23:16];
    tx_buf[2] = a[15:8];
    tx_buf[3] = a[7:0];
  endtask

  // ================================================
  // Commands with the reference model
  // ================================================

  task automatic simple_cmd(input logic [7:0] op);
    tx_buf[0] = op;
    run_frame(1);
    if (op == flash_pkg::op_wren) model_wel = 1'b1;
    if (op == flash_pkg::op_wrdi) model_wel = 1'b0;
  endtask

  task automatic program_run(input logic [23:0] a, input int len);
    logic [31:0] v;
    logic [11:0] ma;
    load_header(flash_pkg::op_program, a);
    for (int i = 0; i < len; i++) begin
      rand_bits(8, v);
      tx_buf[4 + i] = v[7:0];
    end
    run_frame(4 + len);
    if (model_wel && !model_bp && len > 0) begin
      for (int i = 0; i < len; i++) begin
        ma = {a[11:8], a[7:0] + 8'(i)}; // Stays inside the 256-byte page.
        model_mem[ma] = tx_buf[4 + i];
        model_ok[ma]  = 1'b1;
      end
      model_wel = 1'b0;
    end
  endtask

  task automatic read_check(input logic [23:0] a, input int len);
    logic [11:0] ma;
    load_header(flash_pkg::op_read, a);
    for (int i = 0; i < len; i++) begin
      tx_buf[4 + i] = 8'h00;
    end
    run_frame(4 + len);
    for (int i = 0; i < len; i++) begin
      ma = a[11:0] + 12'(i); // Wraps at the top of the array.
      if (model_ok[ma]) begin
        check_byte($sformatf("miso read at %h", ma), model_mem[ma], rx_buf[4 + i]);
      end
    end
  endtask

  task automatic status_check();
    logic [7:0] exp;
    exp       = {5'b00000, model_bp, model_wel, 1'b0};
    tx_buf[0] = flash_pkg::op_rdsr;
    tx_buf[1] = 8'h00;
    tx_buf[2] = 8'h00;
    run_frame(3);
    check_byte("miso status", exp, rx_buf[1]);
    check_byte("miso status repeat", exp, rx_buf[2]);
  endtask

  task automatic write_status(input logic [7:0] value);
    tx_buf[0] = flash_pkg::op_wrsr;
    tx_buf[1] = value;
    run_frame(2);
    if (model_wel) begin
      model_bp  = value[2];
      model_wel = 1'b0;
    end
  endtask

  // Setting the top bit keeps the opcode clear of every defined command.
  task automatic unknown_check();
    logic [31:0] v;
    rand_bits(7, v);
    tx_buf[0] = {1'b1, v[6:0]};
    for (int i = 1; i < 4; i++) begin
      rand_bits(8, v);
      tx_buf[i] = v[7:0];
    end
    run_frame(4);
    for (int i = 1; i < 4; i++) begin
      check_byte("miso after unknown opcode", 8'hff, rx_buf[i]);
    end
  endtask

  // ================================================
  // Test sequence
  // ================================================

  initial begin
    logic [31:0] v;
    logic [23:0] a;
    int          len;
    reset     = 1'b1;
    ss_n      = 1'b1;
    mosi      = 1'b0;
    lfsr      = 16'd3660;
    model_wel = 1'b0;
    model_bp  = 1'b0;
    check_cnt = 0;
    err_cnt   = 0;
    tmo_cnt   = 0;
    repeat (4) @(posedge sck);
    reset <= 1'b0;
    @(negedge sck);
    check_byte("miso after reset", 8'h01, {7'h00, miso});
    status_check();

    for (int r = 0; r < 6; r++) begin
      rand_bits(24, v);
      a = v[23:0];
      rand_bits(5, v);
      len = int'(v[4:0]) + 1;
      simple_cmd(flash_pkg::op_wren);
      status_check();
      program_run(a, len);
      status_check(); // WEL dropped by the finished program.
      read_check(a, len);
    end

    // No WEL, first after a program and then after write disable.
    program_run(a, len);
    read_check(a, len);
    simple_cmd(flash_pkg::op_wren);
    simple_cmd(flash_pkg::op_wrdi);
    status_check();
    program_run(a, len);
    read_check(a, len);

    rand_bits(4, v);
    a = {12'h000, v[3:0], 8'hfa};
    simple_cmd(flash_pkg::op_wren);
    program_run(a, 12);
    read_check(a, 6);
    read_check({a[23:8], 8'h00}, 6);
    simple_cmd(flash_pkg::op_wren);
    program_run(24'h000ffc, 4);
    simple_cmd(flash_pkg::op_wren);
    program_run(24'h000000, 4);
    read_check(24'h000ffe, 6);

    // Block protect on, then off again.
    simple_cmd(flash_pkg::op_wren);
    write_status(8'h04);
    status_check();
    simple_cmd(flash_pkg::op_wren);
    program_run(a, 8);
    status_check();
    read_check(a, 8);
    write_status(8'h00);
    status_check();
    simple_cmd(flash_pkg::op_wren);
    program_run(a, 8);
    read_check(a, 8);

    unknown_check();
    status_check();
    read_check(a, 8);

    sva_cnt = spi_flash_i.flash_sva_i.fail_cnt;
    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             check_cnt, err_cnt, tmo_cnt, sva_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && sva_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: spi_flash.f
flash_pkg.sv
wb_if.sv
spi_shift_io.sv
flash_cmd_engine.sv
flash_status_regs.sv
flash_mem_array.sv
spi_flash.sv
spi_flash_sva.sv
tb_spi_flash.sv

// File: Bender.yml
package:
  name: spi_flash

sources:
  - flash_pkg.sv
  - wb_if.sv
  - spi_shift_io.sv
  - flash_cmd_engine.sv
  - flash_status_regs.sv
  - flash_mem_array.sv
  - spi_flash.sv
  - target: simulation
    files:
      - spi_flash_sva.sv
      - tb_spi_flash.sv
